//--- logic/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ==============================
  // Flash and sample widths
  // ==============================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 16;

  // Playback wraps here
  localparam logic [FLASH_ADDR_W-1:0] FLASH_LAST_ADDR = 23'h7FFFF;

  // ==============================
  // Sample rate divider
  // ==============================
  localparam int DIV_W = 24;

  // About 22 kHz from 50 MHz
  localparam logic [DIV_W-1:0] DIV_DEFAULT = 24'd2272;
  localparam logic [DIV_W-1:0] SPEED_STEP  = 24'd100;
  localparam logic [DIV_W-1:0] DIV_MIN     = 24'd1000;
  localparam logic [DIV_W-1:0] DIV_MAX     = 24'd9000;

  // ==============================
  // PS/2 scan codes
  // ==============================
  localparam logic [7:0] SC_BREAK = 8'hF0;
  localparam logic [7:0] SC_E     = 8'h24;
  localparam logic [7:0] SC_D     = 8'h23;
  localparam logic [7:0] SC_F     = 8'h2B;
  localparam logic [7:0] SC_B     = 8'h32;
  localparam logic [7:0] SC_R     = 8'h2D;

  localparam int HEX_DIGITS = 6;

  typedef enum logic [2:0] {
    CMD_START,
    CMD_STOP,
    CMD_FWD,
    CMD_BACK,
    CMD_RESTART
  } player_cmd_e;

  typedef struct packed {
    logic        valid;
    player_cmd_e cmd;
  } player_cmd_t;

  typedef struct packed {
    logic                    read;
    logic [FLASH_ADDR_W-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic                    waitrequest;
    logic                    readdatavalid;
    logic [FLASH_DATA_W-1:0] readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic                valid;
    logic [SAMPLE_W-1:0] data;
  } sample_t;

  // Raw push-buttons, low while pressed
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_keys_t;

  // Bit 0 is segment a, bit 6 is segment g, active low
  typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

//--- logic/scan_to_command.sv
`timescale 1ns/10ps
`default_nettype none

module scan_to_command (
  input  wire                  CLK_50M,
  input  wire                  reset,
  input  wire [7:0]            kbd_code,
  input  wire                  kbd_valid,
  output ipod_pkg::player_cmd_t cmd
);

  logic                  break_seen;
  logic                  cmd_valid;
  ipod_pkg::player_cmd_e cmd_code;
  logic                  code_known;
  ipod_pkg::player_cmd_e code_cmd;

  // Make code lookup
  always_comb
  begin
    code_known = 1'b1;
    code_cmd   = ipod_pkg::CMD_START;
    case (kbd_code)
      ipod_pkg::SC_E: code_cmd = ipod_pkg::CMD_START;
      ipod_pkg::SC_D: code_cmd = ipod_pkg::CMD_STOP;
      ipod_pkg::SC_F: code_cmd = ipod_pkg::CMD_FWD;
      ipod_pkg::SC_B: code_cmd = ipod_pkg::CMD_BACK;
      ipod_pkg::SC_R: code_cmd = ipod_pkg::CMD_RESTART;
      default:        code_known = 1'b0;
    endcase
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      break_seen <= 1'b0;
      cmd_valid  <= 1'b0;
    end
    else
    begin
      cmd_valid <= 1'b0;
      if (kbd_valid)
      begin
        if (kbd_code == ipod_pkg::SC_BREAK)
          break_seen <= 1'b1;
        else if (break_seen)
          // Key byte of a release, dropped
          break_seen <= 1'b0;
        else if (code_known)
          cmd_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (kbd_valid)
      cmd_code <= code_cmd;
  end

  assign cmd = '{valid: cmd_valid, cmd: cmd_code};

endmodule

`default_nettype wire

//--- logic/rate_control.sv
`timescale 1ns/10ps
`default_nettype none

module rate_control (
  input  wire                          CLK_50M,
  input  wire                          reset,
  input  wire ipod_pkg::speed_keys_t   keys,
  output logic [ipod_pkg::DIV_W-1:0]   divider,
  output logic                         sample_tick
);

  ipod_pkg::speed_keys_t      key_meta;
  ipod_pkg::speed_keys_t      key_sync;
  ipod_pkg::speed_keys_t      key_prev;
  ipod_pkg::speed_keys_t      key_press;
  logic [ipod_pkg::DIV_W-1:0] speed_offset;
  logic [ipod_pkg::DIV_W-1:0] tick_count;

  // ==============================
  // Key synchronizers
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '1;
      key_sync <= '1;
      key_prev <= '1;
    end
    else
    begin
      key_meta <= keys;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  // One event per high to low step of a key
  assign key_press = key_prev & ~key_sync;

  // ==============================
  // Speed offset
  // ==============================
  assign divider = ipod_pkg::DIV_DEFAULT + speed_offset;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      speed_offset <= '0;
    else if (key_press.reset)
      speed_offset <= '0;
    else if (key_press.up)
    begin
      // Faster playback, shorter period
      if (divider <= ipod_pkg::DIV_MIN + ipod_pkg::SPEED_STEP)
        speed_offset <= ipod_pkg::DIV_MIN - ipod_pkg::DIV_DEFAULT;
      else
        speed_offset <= speed_offset - ipod_pkg::SPEED_STEP;
    end
    else if (key_press.down)
    begin
      if (divider >= ipod_pkg::DIV_MAX - ipod_pkg::SPEED_STEP)
        speed_offset <= ipod_pkg::DIV_MAX - ipod_pkg::DIV_DEFAULT;
      else
        speed_offset <= speed_offset + ipod_pkg::SPEED_STEP;
    end
  end

  // ==============================
  // Sample tick
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_count  <= ipod_pkg::DIV_DEFAULT - 1'b1;
      sample_tick <= 1'b0;
    end
    else if (tick_count == '0)
    begin
      // New divider takes effect on reload
      tick_count  <= divider - 1'b1;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_count  <= tick_count - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/flash_reader.sv
`timescale 1ns/10ps
`default_nettype none

module flash_reader (
  input  wire                                 CLK_50M,
  input  wire                                 reset,
  input  wire                                 fetch_start,
  input  wire [ipod_pkg::FLASH_ADDR_W-1:0]    fetch_addr,
  output ipod_pkg::flash_req_t                flash_req,
  input  wire ipod_pkg::flash_rsp_t           flash_rsp,
  output logic                                word_valid,
  output logic [ipod_pkg::FLASH_DATA_W-1:0]   word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_e;

  state_e                            state;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] req_addr;

  // Address is held steady for the whole request
  assign flash_req = '{read: (state == ST_REQ), address: req_addr};

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state      <= ST_IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        ST_IDLE:
          if (fetch_start)
            state <= ST_REQ;
        ST_REQ:
          // Accepted in a cycle without waitrequest
          if (!flash_rsp.waitrequest)
            state <= ST_WAIT;
        ST_WAIT:
          if (flash_rsp.readdatavalid)
          begin
            word_valid <= 1'b1;
            state      <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_IDLE && fetch_start)
      req_addr <= fetch_addr;
    if (state == ST_WAIT && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

endmodule

`default_nettype wire

//--- logic/playback_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module playback_ctrl (
  input  wire                                 CLK_50M,
  input  wire                                 reset,
  input  wire ipod_pkg::player_cmd_t          cmd,
  input  wire                                 sample_tick,
  output logic                                fetch_start,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0]   fetch_addr,
  input  wire                                 word_valid,
  input  wire [ipod_pkg::FLASH_DATA_W-1:0]    word,
  output ipod_pkg::sample_t                   sample_out
);

  logic                              playing;
  logic                              dir_back;
  logic                              half_upper;
  logic                              fetch_pending;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] addr;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] next_addr;
  logic [ipod_pkg::FLASH_DATA_W-1:0] held_word;
  logic                              first_due;
  logic                              sample_valid;
  logic [ipod_pkg::SAMPLE_W-1:0]     sample_data;

  // First half of a word needs a fresh fetch
  assign first_due   = dir_back ? half_upper : ~half_upper;
  assign fetch_start = sample_tick & playing & first_due;
  assign fetch_addr  = addr;

  // Step with wrap between 0 and the last word
  always_comb
  begin
    if (dir_back)
      next_addr = (addr == '0) ? ipod_pkg::FLASH_LAST_ADDR : addr - 1'b1;
    else
      next_addr = (addr == ipod_pkg::FLASH_LAST_ADDR) ? '0 : addr + 1'b1;
  end

  // ==============================
  // Player state
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing       <= 1'b0;
      dir_back      <= 1'b0;
      half_upper    <= 1'b0;
      fetch_pending <= 1'b0;
      addr          <= '0;
      sample_valid  <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (word_valid && fetch_pending)
      begin
        sample_valid  <= 1'b1;
        half_upper    <= ~half_upper;
        fetch_pending <= 1'b0;
      end
      else if (sample_tick && playing)
      begin
        if (first_due)
          fetch_pending <= 1'b1;
        else
        begin
          // Second half comes from the held word
          sample_valid <= 1'b1;
          half_upper   <= ~half_upper;
          addr         <= next_addr;
        end
      end

      // Commands win over the sample path
      if (cmd.valid)
      begin
        case (cmd.cmd)
          ipod_pkg::CMD_START:
            playing <= 1'b1;
          ipod_pkg::CMD_STOP:
            playing <= 1'b0;
          ipod_pkg::CMD_FWD:
            if (dir_back)
            begin
              dir_back   <= 1'b0;
              half_upper <= 1'b0;
            end
          ipod_pkg::CMD_BACK:
            if (!dir_back)
            begin
              dir_back   <= 1'b1;
              half_upper <= 1'b1;
            end
          ipod_pkg::CMD_RESTART:
          begin
            addr          <= '0;
            half_upper    <= dir_back;
            fetch_pending <= 1'b0;
          end
          default:
            playing <= playing;
        endcase
      end
    end
  end

  // Held word and sample payload
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid && fetch_pending)
    begin
      held_word   <= word;
      sample_data <= half_upper ? word[2*ipod_pkg::SAMPLE_W-1:ipod_pkg::SAMPLE_W]
                                : word[ipod_pkg::SAMPLE_W-1:0];
    end
    else if (sample_tick && playing && !first_due)
      sample_data <= half_upper ? held_word[2*ipod_pkg::SAMPLE_W-1:ipod_pkg::SAMPLE_W]
                                : held_word[ipod_pkg::SAMPLE_W-1:0];
  end

  assign sample_out = '{valid: sample_valid, data: sample_data};

endmodule

`default_nettype wire

//--- logic/hex_display.sv
`timescale 1ns/10ps
`default_nettype none

module hex_display (
  input  wire                                           CLK_50M,
  input  wire                                           reset,
  input  wire [ipod_pkg::DIV_W-1:0]                     divider,
  output ipod_pkg::seg7_t [ipod_pkg::HEX_DIGITS-1:0]    hex
);

  // Active low, segment g in bit 6
  function automatic ipod_pkg::seg7_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0:    seg_decode = 7'h40;
      4'h1:    seg_decode = 7'h79;
      4'h2:    seg_decode = 7'h24;
      4'h3:    seg_decode = 7'h30;
      4'h4:    seg_decode = 7'h19;
      4'h5:    seg_decode = 7'h12;
      4'h6:    seg_decode = 7'h02;
      4'h7:    seg_decode = 7'h78;
      4'h8:    seg_decode = 7'h00;
      4'h9:    seg_decode = 7'h10;
      4'hA:    seg_decode = 7'h08;
      4'hB:    seg_decode = 7'h03;
      4'hC:    seg_decode = 7'h46;
      4'hD:    seg_decode = 7'h21;
      4'hE:    seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      hex <= '1;
    else
    begin
      // Digit 0 shows the lowest nibble
      for (int i = 0; i < ipod_pkg::HEX_DIGITS; i++)
        hex[i] <= seg_decode(divider[4*i +: 4]);
    end
  end

endmodule

`default_nettype wire

//--- logic/ipod_top.sv
`timescale 1ns/10ps
`default_nettype none

module ipod_top (
  input  wire                                              CLK_50M,
  input  wire                                              reset,
  input  wire [7:0]                                        kbd_code,
  input  wire                                              kbd_valid,
  input  wire ipod_pkg::speed_keys_t                       keys,
  output wire ipod_pkg::flash_req_t                        flash_req,
  input  wire ipod_pkg::flash_rsp_t                        flash_rsp,
  output wire ipod_pkg::sample_t                           sample_out,
  output wire ipod_pkg::seg7_t [ipod_pkg::HEX_DIGITS-1:0]  hex
);

  wire ipod_pkg::player_cmd_t        cmd;
  wire [ipod_pkg::DIV_W-1:0]         divider;
  wire                               sample_tick;
  wire                               fetch_start;
  wire [ipod_pkg::FLASH_ADDR_W-1:0]  fetch_addr;
  wire                               word_valid;
  wire [ipod_pkg::FLASH_DATA_W-1:0]  word;

  // ==============================
  // Keyboard and rate
  // ==============================
  scan_to_command scan0 (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .kbd_code  (kbd_code),
    .kbd_valid (kbd_valid),
    .cmd       (cmd)
  );

  rate_control rate0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .keys        (keys),
    .divider     (divider),
    .sample_tick (sample_tick)
  );

  // ==============================
  // Playback path
  // ==============================
  playback_ctrl play0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .cmd         (cmd),
    .sample_tick (sample_tick),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .word_valid  (word_valid),
    .word        (word),
    .sample_out  (sample_out)
  );

  flash_reader flash0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .flash_req   (flash_req),
    .flash_rsp   (flash_rsp),
    .word_valid  (word_valid),
    .word        (word)
  );

  // Divider shown in hex
  hex_display hex0 (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .divider (divider),
    .hex     (hex)
  );

endmodule

`default_nettype wire

//--- test/tb_flash_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_flash_model (
  input  wire                        CLK_50M,
  input  wire                        reset,
  input  wire ipod_pkg::flash_req_t  flash_req,
  output ipod_pkg::flash_rsp_t       flash_rsp
);

  integer      seed;
  logic [3:0]  wait_cnt;
  logic [4:0]  lat_cnt;
  logic        pending;
  logic        data_valid;
  logic [31:0] data_q;

  initial seed = 32'h1e4f1d36;

  // Lower half is the address, upper half the address scrambled
  function automatic logic [31:0] word_at(input logic [22:0] addr);
    return {addr[15:0] ^ 16'hA5A5, addr[15:0]};
  endfunction

  assign flash_rsp = '{
    waitrequest:   flash_req.read && (wait_cnt != 4'd0),
    readdatavalid: data_valid,
    readdata:      data_valid ? data_q : 32'h0
  };

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wait_cnt   <= $unsigned($random(seed)) % 9;
      lat_cnt    <= 5'd1;
      pending    <= 1'b0;
      data_valid <= 1'b0;
      data_q     <= 32'h0;
    end
    else
    begin
      data_valid <= 1'b0;
      if (flash_req.read)
      begin
        if (wait_cnt != 4'd0)
          wait_cnt <= wait_cnt - 1'b1;
        else
        begin
          // Accepted, stall for the next read drawn now
          wait_cnt <= $unsigned($random(seed)) % 9;
          lat_cnt  <= 1 + $unsigned($random(seed)) % 16;
          data_q   <= word_at(flash_req.address);
          pending  <= 1'b1;
        end
      end

      // Read latency of 1 to 16 cycles
      if (pending)
      begin
        if (lat_cnt == 5'd1)
        begin
          data_valid <= 1'b1;
          pending    <= 1'b0;
        end
        else
          lat_cnt <= lat_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_ipod.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ipod;

  logic                                       CLK_50M;
  logic                                       reset;
  logic [7:0]                                 kbd_code;
  logic                                       kbd_valid;
  ipod_pkg::speed_keys_t                      keys;
  ipod_pkg::flash_req_t                       flash_req;
  ipod_pkg::flash_rsp_t                       flash_rsp;
  ipod_pkg::sample_t                          sample_out;
  ipod_pkg::seg7_t [ipod_pkg::HEX_DIGITS-1:0] hex;

  // Reference player state
  logic [ipod_pkg::FLASH_ADDR_W-1:0] ref_addr;
  int                                ref_phase;
  bit                                ref_back;
  ipod_pkg::speed_keys_t             key_log [0:63];
  int                                key_count;
  ipod_pkg::speed_keys_t             up_key;
  ipod_pkg::speed_keys_t             down_key;
  ipod_pkg::speed_keys_t             rst_key;

  ipod_pkg::sample_t exp_q[$];
  bit                second_q[$];
  ipod_pkg::sample_t exp_s;
  bit                exp_second;
  time               last_second_t;

  ipod_top dut0 (
    .CLK_50M    (CLK_50M),
    .reset      (reset),
    .kbd_code   (kbd_code),
    .kbd_valid  (kbd_valid),
    .keys       (keys),
    .flash_req  (flash_req),
    .flash_rsp  (flash_rsp),
    .sample_out (sample_out),
    .hex        (hex)
  );

  tb_flash_model flash_model0 (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Reference model
  // ==============================
  function automatic logic [ipod_pkg::FLASH_ADDR_W-1:0] ref_word(
    input logic [ipod_pkg::FLASH_ADDR_W-1:0] start, input bit back, input int steps);
    int span;
    int w;
    span = ipod_pkg::FLASH_LAST_ADDR + 1;
    if (back)
      w = (int'(start) - (steps % span) + span) % span;
    else
      w = (int'(start) + steps) % span;
    return w[ipod_pkg::FLASH_ADDR_W-1:0];
  endfunction

  // Sample k of a run that starts at a word and a half position
  function automatic logic [15:0] ref_sample(
    input logic [ipod_pkg::FLASH_ADDR_W-1:0] start, input int phase,
    input bit back, input int k);
    int                                t;
    bit                                upper;
    logic [ipod_pkg::FLASH_ADDR_W-1:0] w;
    t     = phase + k;
    w     = ref_word(start, back, t / 2);
    upper = back ? (t % 2 == 0) : (t % 2 == 1);
    return upper ? (w[15:0] ^ 16'hA5A5) : w[15:0];
  endfunction

  function automatic logic [ipod_pkg::DIV_W-1:0] ref_divider(input int n);
    int d;
    int i;
    d = ipod_pkg::DIV_DEFAULT;
    for (i = 0; i < n; i++)
    begin
      if (!key_log[i].reset)
        d = ipod_pkg::DIV_DEFAULT;
      else if (!key_log[i].up)
      begin
        d = d - int'(ipod_pkg::SPEED_STEP);
        if (d < int'(ipod_pkg::DIV_MIN))
          d = ipod_pkg::DIV_MIN;
      end
      else if (!key_log[i].down)
      begin
        d = d + int'(ipod_pkg::SPEED_STEP);
        if (d > int'(ipod_pkg::DIV_MAX))
          d = ipod_pkg::DIV_MAX;
      end
    end
    return d[ipod_pkg::DIV_W-1:0];
  endfunction

  function automatic ipod_pkg::seg7_t seg_pattern(input logic [3:0] nibble);
    logic [6:0] lit;
    case (nibble)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    // Segments are active low
    return ~lit;
  endfunction

  // ==============================
  // Checks
  // ==============================
  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_sample(input ipod_pkg::sample_t got, input ipod_pkg::sample_t exp);
    if (got !== exp)
      report_failure($sformatf("[FAIL] %0t ns sample %h, expected %h",
                               $time, got.data, exp.data));
  endtask

  task automatic check_hex(input ipod_pkg::seg7_t got, input ipod_pkg::seg7_t exp,
                           input int digit);
    if (got !== exp)
      report_failure($sformatf("[FAIL] %0t ns hex digit %0d shows %h, expected %h",
                               $time, digit, got, exp));
  endtask

  task automatic check_flash_req(input ipod_pkg::flash_req_t got,
                                 input ipod_pkg::flash_req_t exp);
    if (got !== exp)
      report_failure($sformatf("[FAIL] %0t ns flash request %h changed under waitrequest from %h",
                               $time, got, exp));
  endtask

  task automatic check_display();
    logic [ipod_pkg::DIV_W-1:0] div;
    int                         i;
    div = ref_divider(key_count);
    for (i = 0; i < ipod_pkg::HEX_DIGITS; i++)
      check_hex(hex[i], seg_pattern(div[4*i +: 4]), i);
  endtask

  // Samples in order, with spacing of second halves
  always @(negedge CLK_50M)
  begin
    if (!reset && sample_out.valid)
    begin
      if (exp_q.size() == 0)
        report_failure("A sample came out while the player should be silent");
      else
      begin
        exp_s      = exp_q.pop_front();
        exp_second = second_q.pop_front();
        check_sample(sample_out, exp_s);
        if (exp_second)
        begin
          // Second halves come two ticks apart on the 20 ns clock
          if (last_second_t != 0 &&
              $time - last_second_t != 40 * ref_divider(key_count))
            report_failure($sformatf("[FAIL] %0t ns sample spacing %0d ns, expected %0d ns",
                                     $time, $time - last_second_t,
                                     40 * ref_divider(key_count)));
          last_second_t = $time;
        end
      end
    end
  end

  // Request must hold while the flash stalls it
  ipod_pkg::flash_req_t held_req;
  bit                   held;

  always @(negedge CLK_50M)
  begin
    if (held)
      check_flash_req(flash_req, held_req);
    held     = !reset && flash_req.read && flash_rsp.waitrequest;
    held_req = flash_req;
  end

  // ==============================
  // Stimulus
  // ==============================
  task automatic send_code(input logic [7:0] code);
    @(posedge CLK_50M);
    kbd_code  <= code;
    kbd_valid <= 1'b1;
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
    repeat (2) @(posedge CLK_50M);
  endtask

  // Make code, then the release sequence
  task automatic type_key(input logic [7:0] code);
    send_code(code);
    send_code(ipod_pkg::SC_BREAK);
    send_code(code);
  endtask

  task automatic press_key(input ipod_pkg::speed_keys_t pressed);
    @(posedge CLK_50M);
    keys <= pressed;
    repeat (4) @(posedge CLK_50M);
    keys <= '1;
    repeat (4) @(posedge CLK_50M);
    key_log[key_count] = pressed;
    key_count++;
    @(negedge CLK_50M);
    check_display();
  endtask

  task automatic expect_samples(input int n);
    ipod_pkg::sample_t s;
    int                k;
    int                t;
    for (k = 0; k < n; k++)
    begin
      s.valid = 1'b1;
      s.data  = ref_sample(ref_addr, ref_phase, ref_back, k);
      exp_q.push_back(s);
      second_q.push_back((ref_phase + k) % 2 == 1);
    end
    t         = ref_phase + n;
    ref_addr  = ref_word(ref_addr, ref_back, t / 2);
    ref_phase = t % 2;
    last_second_t = 0;
  endtask

  task automatic turn_ref(input bit back);
    // New direction starts the current word afresh
    if (back != ref_back)
    begin
      ref_back  = back;
      ref_phase = 0;
    end
  endtask

  task automatic drain_samples();
    while (exp_q.size() != 0)
      @(negedge CLK_50M);
  endtask

  task automatic quiet_wait(input int periods);
    repeat (periods * ref_divider(key_count))
    begin
      @(negedge CLK_50M);
      if (flash_req.read)
        report_failure("A flash read was issued while the player is stopped");
    end
  endtask

  task automatic play_run(input int n);
    expect_samples(n);
    type_key(ipod_pkg::SC_E);
    drain_samples();
    type_key(ipod_pkg::SC_D);
  endtask

  initial
  begin
    reset     = 1'b1;
    kbd_code  = 8'h00;
    kbd_valid = 1'b0;
    keys      = '1;
    up_key    = 3'b011;
    down_key  = 3'b101;
    rst_key   = 3'b110;
    key_count = 0;
    ref_addr  = '0;
    ref_phase = 0;
    ref_back  = 1'b0;
    held      = 1'b0;
    last_second_t = 0;
    repeat (5) @(posedge CLK_50M);
    reset <= 1'b0;

    // Idle after reset
    quiet_wait(3);
    check_display();

    // Forward from address 0, then stop
    expect_samples(40);
    type_key(ipod_pkg::SC_E);
    type_key(ipod_pkg::SC_F);
    drain_samples();
    type_key(ipod_pkg::SC_D);
    // A release of E alone must not start playback
    send_code(ipod_pkg::SC_BREAK);
    send_code(ipod_pkg::SC_E);
    quiet_wait(3);

    // Resume, stopping in the middle of a word
    play_run(11);

    // ==============================
    // Backward through the wrap
    // ==============================
    type_key(ipod_pkg::SC_B);
    turn_ref(1'b1);
    expect_samples(2 * ref_addr + 5);
    type_key(ipod_pkg::SC_E);
    drain_samples();
    ref_addr  = '0;
    ref_phase = 0;
    expect_samples(4);
    type_key(ipod_pkg::SC_R);
    drain_samples();
    type_key(ipod_pkg::SC_D);

    // Speed keys, clamping at the fast end
    repeat (15) press_key(up_key);
    type_key(ipod_pkg::SC_F);
    turn_ref(1'b0);
    play_run(12);
    repeat (3) press_key(down_key);
    press_key(rst_key);
    repeat (2) press_key(down_key);
    play_run(6);
    quiet_wait(2);

    $display("Simulation PASSED");
    $finish;
  end

  // Budget of 128 planned samples at the slowest rate, doubled
  initial
  begin
    repeat (128 * ipod_pkg::DIV_MAX * 2) @(posedge CLK_50M);
    report_failure("The run timed out before all samples arrived");
  end

endmodule

`default_nettype wire

//--- src.f
logic/ipod_pkg.sv
logic/scan_to_command.sv
logic/rate_control.sv
logic/flash_reader.sv
logic/playback_ctrl.sv
logic/hex_display.sv
logic/ipod_top.sv
test/tb_flash_model.sv
test/tb_ipod.sv
